// File: sim.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/fetch_stage.sv
rtl/decoder.sv
rtl/execute_stage.sv
rtl/hazard_unit.sv
rtl/processor.sv
verif/processor_checker.sv
verif/tb_processor.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= sim.f
TOP        ?= tb_processor
RTL_TOP    ?= processor
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing --assert
PASS_TEXT  ?= === PASS ===

# RTL sources in compile order, taken from the file list
RTL_FILES ?= $(shell grep '^rtl/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_processor.sv
// Testbench top for the core; models memories and register file and runs a table-driven program
`timescale 1ns/100ps
module tb_processor
  import cpu_pkg::*;
();

  localparam int exp_none = 0;
  localparam int exp_reg  = 1;
  localparam int exp_mem  = 2;

  // One program row; a and b are register and value, or address and data
  typedef struct packed {
    int    addr;
    int    kind;
    word_t instr;
    word_t a;
    word_t b;
  } row_t;

  logic      clock = 1'b0;
  logic      reset;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  reg_addr_t rf_addr_a;
  reg_addr_t rf_addr_b;
  word_t     rf_data_a;
  word_t     rf_data_b;
  rf_write_t rf_write;

  word_t imem [64];
  word_t dmem [256];
  word_t rf [32];
  row_t  prog [$];
  int    cycles;
  int    pending;
  int    pass_count;
  int    error_count;
  logic  timed_out;

  processor #(
    .reset_pc (32'd0)
  ) dut_i (
    .clock      (clock),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .rf_addr_a  (rf_addr_a),
    .rf_addr_b  (rf_addr_b),
    .rf_data_a  (rf_data_a),
    .rf_data_b  (rf_data_b),
    .rf_write   (rf_write)
  );

  processor_checker checker_i (
    .clock       (clock),
    .reset       (reset),
    .rf_write    (rf_write),
    .dmem_req    (dmem_req),
    .pending     (pending),
    .pass_count  (pass_count),
    .error_count (error_count)
  );

  always #10 clock = ~clock;

  // Instruction encoders following the ISA field layout
  function automatic word_t alu_instr(alu_op_t fn, int rd, int rs, int rt, int sh);
    return {op_alu, rd[4:0], rs[4:0], rt[4:0], sh[4:0], fn, 2'b00};
  endfunction

  function automatic word_t imm_instr(opcode_t op, int rd, int rs, int imm);
    return {op, rd[4:0], rs[4:0], imm[16:0]};
  endfunction

  function automatic word_t jump_instr(opcode_t op, int tgt);
    return {op, tgt[26:0]};
  endfunction

  // Write-through read, r0 always zero
  function automatic word_t rf_read(reg_addr_t addr, rf_write_t wr, word_t cur);
    if (addr == '0) begin
      return '0;
    end
    if (wr.enable && wr.waddr == addr) begin
      return wr.wdata;
    end
    return cur;
  endfunction

  always_comb begin
    imem_data  = reset ? '0 : imem[imem_addr[5:0]];
    dmem_rdata = reset ? '0 : dmem[dmem_req.addr[7:0]];
    rf_data_a  = reset ? '0 : rf_read(rf_addr_a, rf_write, rf[rf_addr_a]);
    rf_data_b  = reset ? '0 : rf_read(rf_addr_b, rf_write, rf[rf_addr_b]);
  end

  // Register file and data memory; data words hold their own address during reset
  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        rf[5'(i)] <= '0;
      end
      for (int i = 0; i < 256; i++) begin
        dmem[8'(i)] <= 32'hd000_0000 + word_t'(i);
      end
    end else begin
      if (rf_write.enable && rf_write.waddr != '0) begin
        rf[rf_write.waddr] <= rf_write.wdata;
      end
      if (dmem_req.write) begin
        dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
      end
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
    end
  end

  task automatic add_row(int addr, word_t instr, int kind, word_t a, word_t b);
    row_t row;
    row.addr  = addr;
    row.kind  = kind;
    row.instr = instr;
    row.a     = a;
    row.b     = b;
    prog.push_back(row);
  endtask

  // Rows in execution order; squashed slots carry no expectation
  task automatic fill_table();
    // Dependent ALU chain through memory and writeback bypass
    add_row(0, imm_instr(op_addi, 1, 0, 5), exp_reg, 32'd1, 32'd5);
    add_row(1, imm_instr(op_addi, 2, 0, 3), exp_reg, 32'd2, 32'd3);
    add_row(2, alu_instr(alu_add, 3, 1, 2, 0), exp_reg, 32'd3, 32'd8);
    add_row(3, alu_instr(alu_sub, 4, 3, 1, 0), exp_reg, 32'd4, 32'd3);
    add_row(4, alu_instr(alu_or, 5, 4, 3, 0), exp_reg, 32'd5, 32'h0000_000b);
    add_row(5, alu_instr(alu_and, 6, 5, 3, 0), exp_reg, 32'd6, 32'd8);
    // Negative immediate and shifts
    add_row(6, imm_instr(op_addi, 7, 0, -20), exp_reg, 32'd7, 32'hffff_ffec);
    add_row(7, alu_instr(alu_sll, 8, 7, 0, 4), exp_reg, 32'd8, 32'hffff_fec0);
    add_row(8, alu_instr(alu_sra, 9, 8, 0, 3), exp_reg, 32'd9, 32'hffff_ffd8);
    // Store of fresh data, load, load-use stall, store right behind a load
    add_row(9, imm_instr(op_addi, 10, 0, 16), exp_reg, 32'd10, 32'd16);
    add_row(10, imm_instr(op_addi, 11, 0, 77), exp_reg, 32'd11, 32'd77);
    add_row(11, imm_instr(op_sw, 11, 10, 4), exp_mem, 32'd20, 32'd77);
    add_row(12, imm_instr(op_lw, 12, 10, 4), exp_reg, 32'd12, 32'd77);
    add_row(13, alu_instr(alu_add, 13, 12, 1, 0), exp_reg, 32'd13, 32'd82);
    add_row(14, imm_instr(op_lw, 14, 10, 0), exp_reg, 32'd14, 32'hd000_0010);
    add_row(15, imm_instr(op_sw, 14, 10, 8), exp_mem, 32'd24, 32'hd000_0010);
    // Taken bne and blt, then both untaken
    add_row(16, imm_instr(op_bne, 1, 2, 2), exp_none, '0, '0);
    add_row(17, imm_instr(op_addi, 15, 0, 1), exp_none, '0, '0);
    add_row(18, imm_instr(op_addi, 15, 0, 2), exp_none, '0, '0);
    add_row(19, imm_instr(op_blt, 7, 1, 2), exp_none, '0, '0);
    add_row(20, imm_instr(op_addi, 16, 0, 1), exp_none, '0, '0);
    add_row(21, imm_instr(op_addi, 16, 0, 2), exp_none, '0, '0);
    add_row(22, imm_instr(op_bne, 3, 6, 2), exp_none, '0, '0);
    add_row(23, imm_instr(op_addi, 15, 0, 7), exp_reg, 32'd15, 32'd7);
    // 5 < -20 is false only as a signed compare
    add_row(24, imm_instr(op_blt, 1, 7, 2), exp_none, '0, '0);
    add_row(25, imm_instr(op_addi, 16, 0, 9), exp_reg, 32'd16, 32'd9);
    // Call at 26, body at 30, return to 27, then j over the body
    add_row(26, jump_instr(op_jal, 30), exp_reg, 32'd31, 32'd27);
    add_row(30, imm_instr(op_addi, 18, 0, 44), exp_reg, 32'd18, 32'd44);
    add_row(31, imm_instr(op_jr, 31, 0, 0), exp_none, '0, '0);
    add_row(27, imm_instr(op_addi, 17, 0, 33), exp_reg, 32'd17, 32'd33);
    add_row(28, jump_instr(op_j, 32), exp_none, '0, '0);
    add_row(29, imm_instr(op_addi, 19, 0, 55), exp_none, '0, '0);
    // r0 as destination and as source
    add_row(32, imm_instr(op_addi, 0, 0, 99), exp_none, '0, '0);
    add_row(33, alu_instr(alu_add, 20, 0, 1, 0), exp_reg, 32'd20, 32'd5);
    add_row(34, alu_instr(alu_add, 0, 1, 2, 0), exp_none, '0, '0);
    add_row(35, alu_instr(alu_or, 21, 0, 0, 0), exp_reg, 32'd21, 32'd0);
    add_row(36, jump_instr(op_j, 36), exp_none, '0, '0);
  endtask

  initial begin
    int limit;
    $timeformat(-9, 0, " ns", 0);
    reset     <= 1'b1;
    timed_out = 1'b0;
    fill_table();
    limit = 5 * prog.size() + 40;
    @(posedge clock);
    // Unused slots jump to themselves
    for (int i = 0; i < 64; i++) begin
      imem[6'(i)] <= jump_instr(op_j, i);
    end
    foreach (prog[i]) begin
      imem[prog[i].addr[5:0]] <= prog[i].instr;
      if (prog[i].kind == exp_reg) begin
        checker_i.expect_write(prog[i].a[4:0], prog[i].b);
      end else if (prog[i].kind == exp_mem) begin
        checker_i.queue_store(prog[i].a, prog[i].b);
      end
    end
    repeat (7) @(posedge clock);
    reset <= 1'b0;
    while (pending != 0 && cycles < limit) begin
      @(posedge clock);
    end
    if (pending != 0) begin
      timed_out = 1'b1;
      $display("timeout after %0d cycles with %0d expected writes still missing",
               cycles, pending);
    end else begin
      // Room for any stray write after the last expected one
      repeat (10) @(posedge clock);
    end
    $display("%0d checks passed, %0d failed", pass_count, error_count);
    if (!timed_out && error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verif/processor_checker.sv
// Scoreboard for the core testbench; compares register writes and stores with queued expectations
`timescale 1ns/100ps
module processor_checker
  import cpu_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  rf_write_t rf_write,
  input  dmem_req_t dmem_req,
  output int        pending,
  output int        pass_count,
  output int        error_count
);

  // Expectations in program execution order
  rf_write_t wr_q[$];
  dmem_req_t st_q[$];

  // Filled by the testbench while the program is loaded
  task automatic expect_write(reg_addr_t waddr, word_t wdata);
    wr_q.push_back('{enable: 1'b1, waddr: waddr, wdata: wdata});
  endtask

  task automatic queue_store(word_t addr, word_t wdata);
    st_q.push_back('{addr: addr, wdata: wdata, write: 1'b1});
  endtask

  task automatic write_check();
    rf_write_t exp;
    logic      ok;
    ok = 1'b1;
    if (wr_q.size() == 0) begin
      // Nothing left to expect, so a squashed or r0 write leaked out
      $display("%0t unexpected register write to r%0d with value %h", $time,
               rf_write.waddr, rf_write.wdata);
      error_count++;
    end else begin
      exp = wr_q.pop_front();
      if (rf_write.waddr != exp.waddr) begin
        $display("[ERROR] %0t rf_write.waddr expected %0d got %0d", $time,
                 exp.waddr, rf_write.waddr);
        ok = 1'b0;
      end
      if (rf_write.wdata != exp.wdata) begin
        $display("[ERROR] %0t rf_write.wdata expected %h got %h", $time,
                 exp.wdata, rf_write.wdata);
        ok = 1'b0;
      end
      if (ok) begin
        pass_count++;
        $display("%0t write r%0d = %h ok", $time, rf_write.waddr, rf_write.wdata);
      end else begin
        error_count++;
      end
    end
  endtask

  task automatic store_check();
    dmem_req_t exp;
    logic      ok;
    ok = 1'b1;
    if (st_q.size() == 0) begin
      $display("%0t unexpected store to address %h with data %h", $time,
               dmem_req.addr, dmem_req.wdata);
      error_count++;
    end else begin
      exp = st_q.pop_front();
      if (dmem_req.addr != exp.addr) begin
        $display("[ERROR] %0t dmem_req.addr expected %h got %h", $time,
                 exp.addr, dmem_req.addr);
        ok = 1'b0;
      end
      if (dmem_req.wdata != exp.wdata) begin
        $display("[ERROR] %0t dmem_req.wdata expected %h got %h", $time,
                 exp.wdata, dmem_req.wdata);
        ok = 1'b0;
      end
      if (ok) begin
        pass_count++;
        $display("%0t store [%h] = %h ok", $time, dmem_req.addr, dmem_req.wdata);
      end else begin
        error_count++;
      end
    end
  endtask

  // Write port and store port are sampled at the edge that commits them
  always @(posedge clock) begin
    if (!reset) begin
      if (rf_write.enable) begin
        write_check();
      end
      if (dmem_req.write) begin
        store_check();
      end
    end
    pending <= wr_q.size() + st_q.size();
  end

endmodule

// File: rtl/processor.sv
// Top of the five-stage core; memories and register file are attached outside
`timescale 1ns/100ps
module processor
  import cpu_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic      clock,
  input  logic      reset,
  output word_t     imem_addr,
  input  word_t     imem_data,
  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata,
  output reg_addr_t rf_addr_a,
  output reg_addr_t rf_addr_b,
  input  word_t     rf_data_a,
  input  word_t     rf_data_b,
  output rf_write_t rf_write
);

  word_t     fd_instr;
  word_t     fd_pc1;
  logic      fd_valid;
  logic      stall;
  logic      flush;
  logic      redirect;
  word_t     target;
  ctrl_t     dec_ctrl;
  dx_t       dx;
  xm_t       xm;
  fwd_sel_t  fwd_a;
  fwd_sel_t  fwd_b;

  // Memory/writeback register
  logic      mw_valid;
  logic      mw_reg_write;
  logic      mw_mem_to_reg;
  logic      mw_link;
  reg_addr_t mw_rd;
  word_t     mw_alu;
  word_t     mw_load;
  word_t     mw_pc1;

  fetch_stage #(
    .reset_pc (reset_pc)
  ) fetch_i (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall),
    .redirect  (redirect),
    .target    (target),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .fd_instr  (fd_instr),
    .fd_pc1    (fd_pc1),
    .fd_valid  (fd_valid)
  );

  decoder decoder_i (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall),
    .flush     (flush),
    .fd_instr  (fd_instr),
    .fd_pc1    (fd_pc1),
    .fd_valid  (fd_valid),
    .rf_data_a (rf_data_a),
    .rf_data_b (rf_data_b),
    .rf_addr_a (rf_addr_a),
    .rf_addr_b (rf_addr_b),
    .dec_ctrl  (dec_ctrl),
    .dx        (dx)
  );

  execute_stage execute_i (
    .clock    (clock),
    .reset    (reset),
    .dx       (dx),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .wb_data  (rf_write.wdata),
    .redirect (redirect),
    .target   (target),
    .xm       (xm)
  );

  hazard_unit hazard_i (
    .rf_addr_a (rf_addr_a),
    .rf_addr_b (rf_addr_b),
    .dec_ctrl  (dec_ctrl),
    .dx        (dx),
    .xm        (xm),
    .rf_write  (rf_write),
    .redirect  (redirect),
    .stall     (stall),
    .flush     (flush),
    .fwd_a     (fwd_a),
    .fwd_b     (fwd_b)
  );

  // Memory stage
  assign dmem_req.addr  = xm.alu_result;
  assign dmem_req.write = xm.valid && xm.ctrl.mem_write;
  // sw right behind a lw picks the loaded value from writeback
  assign dmem_req.wdata = (xm.ctrl.mem_write && rf_write.enable && rf_write.waddr == xm.rd)
                          ? rf_write.wdata : xm.store_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      mw_valid     <= 1'b0;
      mw_reg_write <= 1'b0;
    end else begin
      mw_valid     <= xm.valid;
      mw_reg_write <= xm.ctrl.reg_write;
    end
  end

  always_ff @(posedge clock) begin
    mw_mem_to_reg <= xm.ctrl.mem_to_reg;
    mw_link       <= xm.ctrl.link;
    mw_rd         <= xm.rd;
    mw_alu        <= xm.alu_result;
    mw_load       <= dmem_rdata;
    mw_pc1        <= xm.pc1;
  end

  // Writeback stage
  assign rf_write.enable = mw_valid && mw_reg_write;
  assign rf_write.waddr  = mw_rd;

  // Load data, link address or ALU result
  always_comb begin
    if (mw_mem_to_reg) begin
      rf_write.wdata = mw_load;
    end else if (mw_link) begin
      rf_write.wdata = mw_pc1;
    end else begin
      rf_write.wdata = mw_alu;
    end
  end

endmodule

// File: rtl/hazard_unit.sv
// Hazard detection for the core, giving load-use stall, bypass selects and flush
`timescale 1ns/100ps
module hazard_unit
  import cpu_pkg::*;
(
  input  reg_addr_t rf_addr_a,
  input  reg_addr_t rf_addr_b,
  input  ctrl_t     dec_ctrl,
  input  dx_t       dx,
  input  xm_t       xm,
  input  rf_write_t rf_write,
  input  logic      redirect,
  output logic      stall,
  output logic      flush,
  output fwd_sel_t  fwd_a,
  output fwd_sel_t  fwd_b
);

  logic uses_a;
  logic uses_b;
  logic load_in_ex;

  function automatic fwd_sel_t pick(reg_addr_t src, xm_t xm_s, rf_write_t wb);
    if (src == '0) begin
      return fwd_none;
    end
    // Youngest producer first; a load in memory has no data yet
    if (xm_s.ctrl.reg_write && !xm_s.ctrl.mem_to_reg && xm_s.rd == src) begin
      return fwd_mem;
    end
    if (wb.enable && wb.waddr == src) begin
      return fwd_wb;
    end
    return fwd_none;
  endfunction

  // j and jal read no register
  assign uses_a = !dec_ctrl.is_jump;
  // Port B compare only for ALU ops and branches; sw data gets fixed up in memory
  assign uses_b = !dec_ctrl.imm_src && !dec_ctrl.is_jump && !dec_ctrl.is_jr;

  assign load_in_ex = dx.ctrl.mem_to_reg && dx.ctrl.reg_write;
  assign stall      = load_in_ex && ((uses_a && rf_addr_a == dx.rd)
                                     || (uses_b && rf_addr_b == dx.rd));
  assign flush      = redirect;

  assign fwd_a = pick(dx.rs, xm, rf_write);
  assign fwd_b = pick(dx.rt, xm, rf_write);

  // Stores never write a register, so they must not appear as a bypass source
  always_comb begin
    assert (!(xm.ctrl.mem_write && (fwd_a == fwd_mem || fwd_b == fwd_mem)))
      else $error("memory-stage bypass selected from a store");
  end

endmodule

// File: rtl/execute_stage.sv
// Execute stage with operand bypass, branch and jump resolution and the execute/memory register
`timescale 1ns/100ps
module execute_stage
  import cpu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  dx_t      dx,
  input  fwd_sel_t fwd_a,
  input  fwd_sel_t fwd_b,
  input  word_t    wb_data,
  output logic     redirect,
  output word_t    target,
  output xm_t      xm
);

  word_t   mem_data;
  word_t   op_a;
  word_t   op_b;
  word_t   alu_b;
  word_t   result;
  alu_op_t op;
  logic    not_equal;
  logic    less_than;
  logic    is_branch;

  function automatic word_t bypass(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                   word_t wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // Value the instruction now in memory will write back
  assign mem_data = xm.ctrl.link ? xm.pc1 : xm.alu_result;

  assign op_a      = bypass(fwd_a, dx.a, mem_data, wb_data);
  assign op_b      = bypass(fwd_b, dx.b, mem_data, wb_data);
  assign alu_b     = dx.ctrl.imm_src ? dx.imm : op_b;
  assign is_branch = dx.ctrl.is_bne || dx.ctrl.is_blt;

  // Branches subtract for the flags; addi, lw and sw add the immediate
  always_comb begin
    if (is_branch) begin
      op = alu_sub;
    end else if (dx.ctrl.imm_src) begin
      op = alu_add;
    end else begin
      op = dx.alu_op;
    end
  end

  alu alu_i (
    .a         (op_a),
    .b         (alu_b),
    .op        (op),
    .shamt     (dx.shamt),
    .result    (result),
    .not_equal (not_equal),
    .less_than (less_than)
  );

  // Bubbles carry zero controls, so they never redirect
  assign redirect = (dx.ctrl.is_bne && not_equal) || (dx.ctrl.is_blt && less_than)
                    || dx.ctrl.is_jump || dx.ctrl.is_jr;

  always_comb begin
    if (dx.ctrl.is_jr) begin
      target = op_a;
    end else if (dx.ctrl.is_jump) begin
      target = dx.target;
    end else begin
      target = dx.pc1 + dx.imm;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      xm.valid <= 1'b0;
      xm.ctrl  <= '0;
    end else begin
      xm.valid <= dx.valid;
      xm.ctrl  <= dx.ctrl;
    end
  end

  // Store data leaves with the bypassed port B value
  always_ff @(posedge clock) begin
    xm.rd         <= dx.rd;
    xm.alu_result <= result;
    xm.store_data <= op_b;
    xm.pc1        <= dx.pc1;
  end

  // Squashed slots must have been cleared by decode
  ex_redirect_valid: assert property (@(posedge clock) disable iff (reset)
    redirect |-> dx.valid)
    else $error("redirect raised by a bubble");

endmodule

// File: rtl/decoder.sv
// Decode stage turning the fetched word into controls and operands, used by the processor top
`timescale 1ns/100ps
module decoder
  import cpu_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      stall,
  input  logic      flush,
  input  word_t     fd_instr,
  input  word_t     fd_pc1,
  input  logic      fd_valid,
  input  word_t     rf_data_a,
  input  word_t     rf_data_b,
  output reg_addr_t rf_addr_a,
  output reg_addr_t rf_addr_b,
  output ctrl_t     dec_ctrl,
  output dx_t       dx
);

  opcode_t   opcode;
  reg_addr_t f_rd;
  reg_addr_t f_rs;
  reg_addr_t f_rt;
  reg_addr_t dest;
  word_t     imm;
  logic      writes;
  logic      is_branch;

  assign opcode = opcode_t'(fd_instr[op_hi:op_lo]);
  assign f_rd   = fd_instr[rd_hi:rd_lo];
  assign f_rs   = fd_instr[rs_hi:rs_lo];
  assign f_rt   = fd_instr[rt_hi:rt_lo];
  assign imm    = {{15{fd_instr[imm_hi]}}, fd_instr[imm_hi:0]};
  assign dest   = (opcode == op_jal) ? link_reg : f_rd;

  // Branches compare rd against rs; jr jumps through rd; sw stores rd
  assign is_branch = (opcode == op_bne) || (opcode == op_blt);
  assign rf_addr_a = (is_branch || opcode == op_jr) ? f_rd : f_rs;
  assign rf_addr_b = (opcode == op_sw) ? f_rd : (is_branch ? f_rs : f_rt);

  // Invalid slot decodes to all-zero controls
  always_comb begin
    dec_ctrl = '0;
    writes   = 1'b0;
    if (fd_valid) begin
      case (opcode)
        op_alu:  writes = 1'b1;
        op_addi: begin
          writes           = 1'b1;
          dec_ctrl.imm_src = 1'b1;
        end
        op_lw: begin
          writes              = 1'b1;
          dec_ctrl.mem_to_reg = 1'b1;
          dec_ctrl.imm_src    = 1'b1;
        end
        op_sw: begin
          dec_ctrl.mem_write = 1'b1;
          dec_ctrl.imm_src   = 1'b1;
        end
        op_bne: dec_ctrl.is_bne = 1'b1;
        op_blt: dec_ctrl.is_blt = 1'b1;
        op_j:   dec_ctrl.is_jump = 1'b1;
        op_jal: begin
          writes           = 1'b1;
          dec_ctrl.link    = 1'b1;
          dec_ctrl.is_jump = 1'b1;
        end
        op_jr:   dec_ctrl.is_jr = 1'b1;
        default: writes = 1'b0;
      endcase
    end
    // r0 stays zero
    dec_ctrl.reg_write = writes && (dest != '0);
  end

  // Stall and flush both leave a bubble in execute
  always_ff @(posedge clock) begin
    if (reset || stall || flush) begin
      dx.valid <= 1'b0;
      dx.ctrl  <= '0;
    end else begin
      dx.valid <= fd_valid;
      dx.ctrl  <= dec_ctrl;
    end
  end

  always_ff @(posedge clock) begin
    dx.alu_op <= alu_op_t'(fd_instr[fn_hi:fn_lo]);
    dx.shamt  <= fd_instr[sh_hi:sh_lo];
    dx.rs     <= rf_addr_a;
    dx.rt     <= rf_addr_b;
    dx.rd     <= dest;
    dx.a      <= rf_data_a;
    dx.b      <= rf_data_b;
    dx.imm    <= imm;
    dx.pc1    <= fd_pc1;
    dx.target <= {5'b0, fd_instr[tgt_hi:0]};
  end

  // Bypass compares in execute rely on r0 never being a live destination
  dx_no_r0_write: assert property (@(posedge clock) disable iff (reset)
    dx.ctrl.reg_write |-> dx.rd != '0)
    else $error("decode issued a register write to r0");

endmodule

// File: rtl/fetch_stage.sv
// Fetch stage with the program counter and the fetch/decode register, used by the processor top
`timescale 1ns/100ps
module fetch_stage
  import cpu_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  stall,
  input  logic  redirect,
  input  word_t target,
  input  word_t imem_data,
  output word_t imem_addr,
  output word_t fd_instr,
  output word_t fd_pc1,
  output logic  fd_valid
);

  word_t pc;
  word_t pc1;
  word_t pc_next;

  // Word addressed memory, so sequential fetch steps by one
  assign pc1       = pc + 32'd1;
  assign imem_addr = pc;

  // Redirect outranks the load-use hold
  always_comb begin
    if (redirect) begin
      pc_next = target;
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  // Squashed slot decodes as an all-zero word with valid clear
  always_ff @(posedge clock) begin
    if (reset || redirect) begin
      fd_valid <= 1'b0;
      fd_instr <= '0;
    end else if (!stall) begin
      fd_valid <= 1'b1;
      fd_instr <= imem_data;
      fd_pc1   <= pc1;
    end
  end

endmodule

// File: rtl/alu.sv
// Combinational ALU for the execute stage, also producing the branch compare flags
`timescale 1ns/100ps
module alu
  import cpu_pkg::*;
(
  input  word_t     a,
  input  word_t     b,
  input  alu_op_t   op,
  input  reg_addr_t shamt,
  output word_t     result,
  output logic      not_equal,
  output logic      less_than
);

  word_t diff;

  assign diff = a - b;

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = diff;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_sll: result = a << shamt;
      alu_sra: result = word_t'($signed(a) >>> shamt);
      default: result = '0;
    endcase
  end

  // Signed compare from the difference; on mixed signs the sign of a decides
  assign less_than = (a[31] ^ b[31]) ? a[31] : diff[31];
  assign not_equal = |diff;

endmodule

// File: rtl/cpu_pkg.sv
// Types, encodings and stage structs for the five-stage core; each RTL module imports it
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcode in instruction bits 31..27
  typedef enum logic [4:0] {
    op_alu  = 5'd0,
    op_j    = 5'd1,
    op_bne  = 5'd2,
    op_jal  = 5'd3,
    op_jr   = 5'd4,
    op_addi = 5'd5,
    op_blt  = 5'd6,
    op_sw   = 5'd7,
    op_lw   = 5'd8
  } opcode_t;

  // Function code of register ALU instructions
  typedef enum logic [4:0] {
    alu_add = 5'd0,
    alu_sub = 5'd1,
    alu_and = 5'd2,
    alu_or  = 5'd3,
    alu_sll = 5'd4,
    alu_sra = 5'd5
  } alu_op_t;

  // jal always links here
  localparam reg_addr_t link_reg = 5'd31;

  // Bit positions of the instruction fields
  localparam int op_hi  = 31;
  localparam int op_lo  = 27;
  localparam int rd_hi  = 26;
  localparam int rd_lo  = 22;
  localparam int rs_hi  = 21;
  localparam int rs_lo  = 17;
  localparam int rt_hi  = 16;
  localparam int rt_lo  = 12;
  localparam int sh_hi  = 11;
  localparam int sh_lo  = 7;
  localparam int fn_hi  = 6;
  localparam int fn_lo  = 2;
  localparam int imm_hi = 16;
  localparam int tgt_hi = 26;

  typedef struct packed {
    logic reg_write;
    logic mem_write;
    logic mem_to_reg;
    logic link;
    logic imm_src;
    logic is_bne;
    logic is_blt;
    logic is_jump;
    logic is_jr;
  } ctrl_t;

  // Decode to execute; rs and rt are the numbers read on ports A and B
  typedef struct packed {
    logic      valid;
    ctrl_t     ctrl;
    alu_op_t   alu_op;
    reg_addr_t shamt;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     a;
    word_t     b;
    word_t     imm;
    word_t     pc1;
    word_t     target;
  } dx_t;

  // Execute to memory; for sw, rd names the data register
  typedef struct packed {
    logic      valid;
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     alu_result;
    word_t     store_data;
    word_t     pc1;
  } xm_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } dmem_req_t;

  typedef struct packed {
    logic      enable;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_write_t;

  typedef enum logic [1:0] {
    fwd_none = 2'd0,
    fwd_mem  = 2'd1,
    fwd_wb   = 2'd2
  } fwd_sel_t;

endpackage
